//--- soc_bus_cfg.svh
`ifndef SOC_BUS_CFG_SVH
`define SOC_BUS_CFG_SVH

// data ram window
`define RAM_BASE 32'h8000_0000
// depth in 32-bit words, 4 KB
`define RAM_WORDS 1024

// plic window, 4 MB starting here
`define PLIC_BASE 32'h0C00_0000

// priority words sit at offset 0, one word per source id
// pending bitmap
`define PLIC_PENDING_OFS 32'h0000_1000
// enable word of context 0, next context one stride up
`define PLIC_ENABLE_OFS 32'h0000_2000
`define PLIC_ENABLE_STRIDE 32'h0000_0080
// threshold and claim of context 0
`define PLIC_THRESH_OFS 32'h0020_0000
`define PLIC_CLAIM_OFS 32'h0020_0004
// threshold/claim page step per context
`define PLIC_CTX_STRIDE 32'h0000_1000

// source ids, id 0 means no interrupt
`define PLIC_SOURCES 8
// context 0 machine mode, context 1 supervisor mode
`define PLIC_CONTEXTS 2

// priority and threshold width
`define PRIO_W 3

`endif

//--- soc_bus_pkg.sv
`include "soc_bus_cfg.svh"

package soc_bus_pkg;

    // load/store type, stores look at the low two bits only
    typedef enum logic [2:0] {
        ls_lb  = 3'b000,
        ls_lh  = 3'b001,
        ls_lw  = 3'b010,
        ls_ld  = 3'b011,
        ls_lbu = 3'b100,
        ls_lhu = 3'b101,
        ls_lwu = 3'b110
    } ls_size_e;

    // ram view of the address
    typedef struct packed {
        logic [29-$clog2(`RAM_WORDS):0] region;
        logic [$clog2(`RAM_WORDS)-1:0]  word;
        logic [1:0]                     lane;
    } ram_view_t;

    // plic view, 4 MB window split in 4 KB pages
    typedef struct packed {
        logic [9:0] region;
        logic [9:0] page;
        logic [9:0] word;
        logic [1:0] lane;
    } plic_view_t;

    typedef union packed {
        ram_view_t  ram;
        plic_view_t plic;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u   addr;
        logic [63:0] wdata;
        logic        write;
        ls_size_e    size;
    } bus_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        err;
    } bus_resp_t;

    // target answer, done is a single-cycle pulse
    typedef struct packed {
        logic        done;
        logic [63:0] rdata;
    } tgt_rsp_t;

endpackage

//--- bus_decoder.sv
`include "soc_bus_cfg.svh"

module bus_decoder (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  soc_bus_pkg::bus_req_t  req,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output soc_bus_pkg::bus_resp_t resp,
    output soc_bus_pkg::bus_req_t  tgt_req,
    output logic                   ram_start,
    input  soc_bus_pkg::tgt_rsp_t  ram_rsp,
    output logic                   plic_start,
    input  soc_bus_pkg::tgt_rsp_t  plic_rsp
);
    import soc_bus_pkg::*;

    localparam int idx_w = $clog2(`RAM_WORDS);
    localparam logic [31:0] ram_base = `RAM_BASE;
    localparam logic [31:0] plic_base = `PLIC_BASE;

    // fsm states
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_wait = 2'd1;
    localparam logic [1:0] st_resp = 2'd2;

    logic [1:0]  state_q;
    // owner of the transfer in flight
    logic        sel_ram_q;
    logic        ram_start_q;
    logic        plic_start_q;
    bus_req_t    tgt_req_q;
    bus_resp_t   resp_q;

    logic [31:0] addr_w;
    logic        ram_hit;
    logic        plic_hit;
    logic        aligned;
    logic        accept;
    tgt_rsp_t    sel_rsp;

    assign addr_w = req.addr;
    assign ram_hit = req.addr.ram.region == ram_base[31:idx_w+2];
    // plic window is 4 MB
    assign plic_hit = addr_w[31:22] == plic_base[31:22];

    assign req_ready = state_q == st_idle;
    assign resp_valid = state_q == st_resp;
    assign accept = req_valid && req_ready;
    assign sel_rsp = sel_ram_q ? ram_rsp : plic_rsp;

    // natural alignment, width from the low two size bits
    always_comb begin
        case (req.size[1:0])
            2'b00:   aligned = 1'b1;
            2'b01:   aligned = ~req.addr.ram.lane[0];
            2'b10:   aligned = req.addr.ram.lane == 2'b00;
            default: aligned = (req.addr.ram.lane == 2'b00) && !req.addr.ram.word[0];
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state_q <= st_idle;
            sel_ram_q <= 1'b0;
            ram_start_q <= 1'b0;
            plic_start_q <= 1'b0;
        end else begin
            // starts are one-cycle pulses
            ram_start_q <= 1'b0;
            plic_start_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        if (aligned && ram_hit) begin
                            ram_start_q <= 1'b1;
                            sel_ram_q <= 1'b1;
                            state_q <= st_wait;
                        end else if (aligned && plic_hit) begin
                            plic_start_q <= 1'b1;
                            sel_ram_q <= 1'b0;
                            state_q <= st_wait;
                        end else begin
                            // bad address, no target, answer next cycle
                            state_q <= st_wait;
                        end
                    end
                end
                st_wait: begin
                    // err flag was latched on accept
                    if (sel_rsp.done || resp_q.err) begin
                        state_q <= st_resp;
                    end
                end
                st_resp: begin
                    // response held until taken
                    if (resp_ready) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            tgt_req_q <= req;
            resp_q.err <= !(aligned && (ram_hit || plic_hit));
            resp_q.rdata <= '0;
        end else if ((state_q == st_wait) && sel_rsp.done) begin
            // writes answer with zero data
            resp_q.rdata <= tgt_req_q.write ? 64'd0 : sel_rsp.rdata;
        end
    end

    assign tgt_req = tgt_req_q;
    assign resp = resp_q;
    assign ram_start = ram_start_q;
    assign plic_start = plic_start_q;

endmodule

//--- ram_port.sv
`include "soc_bus_cfg.svh"

module ram_port (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  start,
    input  soc_bus_pkg::bus_req_t req,
    output soc_bus_pkg::tgt_rsp_t rsp
);
    localparam int idx_w = $clog2(`RAM_WORDS);

    // little-endian words, lane k holds address ...k
    logic [31:0]      mem [`RAM_WORDS];
    logic [31:0]      rd_word;
    // low half of a double load
    logic [31:0]      rd_lo;
    logic [63:0]      rdata_q;

    // second word cycle of a double
    logic             second_q;
    // result ready to register next edge
    logic             finish_q;
    logic             done_q;

    logic             mem_en;
    logic [idx_w-1:0] mem_idx;
    logic [3:0]       mem_be;
    logic [31:0]      mem_wdata;
    logic [1:0]       lane;
    logic [1:0]       width;
    logic             signed_ld;
    logic [31:0]      ld_shift;
    logic [63:0]      ld_val;

    assign lane = req.addr.ram.lane;
    assign width = req.size[1:0];
    // lbu, lhu, lwu have bit 2 set
    assign signed_ld = ~req.size[2];
    assign mem_en = start | second_q;
    // doubles are 8-byte aligned, high half at the odd index
    assign mem_idx = {req.addr.ram.word[idx_w-1:1], req.addr.ram.word[0] | second_q};

    // store lanes and data placement
    always_comb begin
        mem_be = 4'b0000;
        mem_wdata = req.wdata[31:0] << {lane, 3'b000};
        if (req.write) begin
            case (width)
                2'b00:   mem_be = 4'b0001 << lane;
                2'b01:   mem_be = 4'b0011 << lane;
                default: mem_be = 4'b1111;
            endcase
        end
        if (second_q) begin
            mem_wdata = req.wdata[63:32];
        end
    end

    // load, lane shifted down then extended
    always_comb begin
        ld_shift = rd_word >> {lane, 3'b000};
        case (width)
            2'b00:   ld_val = {{56{signed_ld & ld_shift[7]}}, ld_shift[7:0]};
            2'b01:   ld_val = {{48{signed_ld & ld_shift[15]}}, ld_shift[15:0]};
            2'b10:   ld_val = {{32{signed_ld & ld_shift[31]}}, ld_shift};
            default: ld_val = {rd_word, rd_lo};
        endcase
    end

    // single port, synchronous read
    always_ff @(posedge CLOCK_50) begin
        if (mem_en) begin
            for (int k = 0; k < 4; k++) begin
                if (mem_be[k]) begin
                    mem[mem_idx][8*k +: 8] <= mem_wdata[8*k +: 8];
                end
            end
            rd_word <= mem[mem_idx];
        end
        // keep first word while the second is read
        if (second_q) begin
            rd_lo <= rd_word;
        end
        if (finish_q) begin
            rdata_q <= ld_val;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            second_q <= 1'b0;
            finish_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            second_q <= start && (width == 2'b11);
            finish_q <= (start && (width != 2'b11)) || second_q;
            done_q <= finish_q;
        end
    end

    assign rsp = '{done: done_q, rdata: rdata_q};

endmodule

//--- plic.sv
`include "soc_bus_cfg.svh"

module plic (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  logic                      start,
    input  soc_bus_pkg::bus_req_t     req,
    output soc_bus_pkg::tgt_rsp_t     rsp,
    input  logic [`PLIC_SOURCES-1:0]  irq_src,
    output logic [`PLIC_CONTEXTS-1:0] ext_irq
);
    localparam int nsrc = `PLIC_SOURCES;
    localparam int nctx = `PLIC_CONTEXTS;
    localparam int id_w = $clog2(`PLIC_SOURCES);
    localparam logic [31:0] pend_ofs = `PLIC_PENDING_OFS;
    localparam logic [31:0] en_ofs = `PLIC_ENABLE_OFS;
    localparam logic [31:0] en_stride = `PLIC_ENABLE_STRIDE;
    localparam logic [31:0] th_ofs = `PLIC_THRESH_OFS;
    localparam logic [31:0] cl_ofs = `PLIC_CLAIM_OFS;
    localparam logic [31:0] ctx_stride = `PLIC_CTX_STRIDE;

    // entry 0 stays zero
    logic [`PRIO_W-1:0] prio [nsrc];
    logic [nsrc-1:0]    pending;
    logic [nsrc-1:0]    enable [nctx];
    logic [`PRIO_W-1:0] thresh [nctx];
    logic [id_w-1:0]    cand [nctx];

    logic [nsrc-1:0]    src_q1;
    logic [nsrc-1:0]    src_q2;
    logic [nsrc-1:0]    rise;
    logic [nsrc-1:0]    clr;
    logic               done_q;
    logic [63:0]        rdata_q;
    logic [31:0]        rd_val;

    logic [9:0]         page;
    logic [9:0]         word;
    logic [id_w-1:0]    prio_id;
    logic               sel_prio;
    logic               sel_pend;
    logic [nctx-1:0]    sel_en;
    logic [nctx-1:0]    sel_th;
    logic [nctx-1:0]    sel_cl;

    // register at a byte offset inside the window
    function automatic logic at_ofs(input logic [9:0] pg, input logic [9:0] wd,
                                    input logic [31:0] ofs);
        return (pg == ofs[21:12]) && (wd == ofs[11:2]);
    endfunction

    assign page = req.addr.plic.page;
    assign word = req.addr.plic.word;
    assign prio_id = word[id_w-1:0];
    // id 0 never gets an edge
    assign rise = {src_q1[nsrc-1:1] & ~src_q2[nsrc-1:1], 1'b0};

    // register select
    always_comb begin
        sel_prio = (page == 10'd0) && (word < 10'(nsrc)) && (word != 10'd0);
        sel_pend = at_ofs(page, word, pend_ofs);
        for (int c = 0; c < nctx; c++) begin
            sel_en[c] = at_ofs(page, word, en_ofs + c * en_stride);
            sel_th[c] = at_ofs(page, word, th_ofs + c * ctx_stride);
            sel_cl[c] = at_ofs(page, word, cl_ofs + c * ctx_stride);
        end
    end

    // highest eligible id per context, not highest priority
    always_comb begin
        for (int c = 0; c < nctx; c++) begin
            cand[c] = '0;
            for (int s = 1; s < nsrc; s++) begin
                if (pending[s] && enable[c][s] && (prio[s] > thresh[c])) begin
                    cand[c] = id_w'(s);
                end
            end
            ext_irq[c] = cand[c] != '0;
        end
    end

    // read mux, unused offsets give zero
    always_comb begin
        rd_val = '0;
        clr = '0;
        if (sel_prio) begin
            rd_val[`PRIO_W-1:0] = prio[prio_id];
        end
        if (sel_pend) begin
            rd_val[nsrc-1:0] = pending;
        end
        for (int c = 0; c < nctx; c++) begin
            if (sel_en[c]) begin
                rd_val[nsrc-1:0] = enable[c];
            end
            if (sel_th[c]) begin
                rd_val[`PRIO_W-1:0] = thresh[c];
            end
            if (sel_cl[c]) begin
                rd_val[id_w-1:0] = cand[c];
                // claim read drops the returned id
                if (start && !req.write) begin
                    clr[cand[c]] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            src_q1 <= '0;
            src_q2 <= '0;
            pending <= '0;
            done_q <= 1'b0;
            for (int s = 0; s < nsrc; s++) begin
                prio[s] <= '0;
            end
            for (int c = 0; c < nctx; c++) begin
                enable[c] <= '0;
                thresh[c] <= '0;
            end
        end else begin
            // edge detect on the sampled source lines
            src_q1 <= irq_src;
            src_q2 <= src_q1;
            done_q <= start;
            // a fresh edge beats a claim of the same id
            pending <= (pending & ~clr) | rise;
            // pending and claim ignore writes
            if (start && req.write) begin
                if (sel_prio) begin
                    prio[prio_id] <= req.wdata[`PRIO_W-1:0];
                end
                for (int c = 0; c < nctx; c++) begin
                    if (sel_en[c]) begin
                        enable[c] <= req.wdata[nsrc-1:0];
                    end
                    if (sel_th[c]) begin
                        thresh[c] <= req.wdata[`PRIO_W-1:0];
                    end
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            rdata_q <= {32'd0, rd_val};
        end
    end

    assign rsp = '{done: done_q, rdata: rdata_q};

endmodule

//--- soc_bus_top.sv
`include "soc_bus_cfg.svh"

module soc_bus_top (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  soc_bus_pkg::bus_req_t     req,
    output logic                      resp_valid,
    input  logic                      resp_ready,
    output soc_bus_pkg::bus_resp_t    resp,
    input  logic [`PLIC_SOURCES-1:0]  irq_src,
    output logic [`PLIC_CONTEXTS-1:0] ext_irq
);
    import soc_bus_pkg::*;

    // request held by the decoder for the active target
    bus_req_t tgt_req;
    logic     ram_start;
    logic     plic_start;
    tgt_rsp_t ram_rsp;
    tgt_rsp_t plic_rsp;

    bus_decoder u_decoder (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .tgt_req    (tgt_req),
        .ram_start  (ram_start),
        .ram_rsp    (ram_rsp),
        .plic_start (plic_start),
        .plic_rsp   (plic_rsp)
    );

    ram_port u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .start    (ram_start),
        .req      (tgt_req),
        .rsp      (ram_rsp)
    );

    plic u_plic (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .start    (plic_start),
        .req      (tgt_req),
        .rsp      (plic_rsp),
        .irq_src  (irq_src),
        .ext_irq  (ext_irq)
    );

endmodule

//--- soc_bus_properties.sv
`include "soc_bus_cfg.svh"

module soc_bus_properties (
    input logic                      CLOCK_50,
    input logic                      KEY0,
    input logic                      req_valid,
    input logic                      req_ready,
    input soc_bus_pkg::bus_req_t     req,
    input logic                      resp_valid,
    input logic                      resp_ready,
    input soc_bus_pkg::bus_resp_t    resp,
    input logic                      ram_start,
    input logic                      plic_start,
    input logic [`PLIC_CONTEXTS-1:0] ext_irq
);
    // master holds request until accepted
    req_hold: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else $error("request changed while waiting for ready");

    // response stays put under back-pressure
    resp_hold: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
        else $error("response changed while waiting for ready");

    // one transaction at a time
    ready_excl: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        resp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending");

    start_excl: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(ram_start && plic_start))
        else $error("both target starts high");

    // plic comes out of reset quiet
    irq_reset: assert property (@(posedge CLOCK_50) $rose(KEY0) |-> (ext_irq == '0))
        else $error("ext_irq set right after reset");

endmodule

// handshake side on the decoder
bind bus_decoder soc_bus_properties u_dec_props (
    .CLOCK_50   (CLOCK_50),
    .KEY0       (KEY0),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .ram_start  (ram_start),
    .plic_start (plic_start),
    .ext_irq    ('0)
);

// interrupt side on the plic, bus lines tied idle
bind plic soc_bus_properties u_plic_props (
    .CLOCK_50   (CLOCK_50),
    .KEY0       (KEY0),
    .req_valid  (1'b0),
    .req_ready  (1'b1),
    .req        ('0),
    .resp_valid (1'b0),
    .resp_ready (1'b1),
    .resp       ('0),
    .ram_start  (1'b0),
    .plic_start (start),
    .ext_irq    (ext_irq)
);

//--- tb_soc_bus_top.sv
`include "soc_bus_cfg.svh"

module tb_soc_bus_top;
    import soc_bus_pkg::*;

    // rough transaction count over all tests
    localparam int num_trans = 130;
    localparam int clk_period = 4;
    localparam logic [31:0] ram = `RAM_BASE;
    localparam logic [31:0] pl = `PLIC_BASE;

    logic                       CLOCK_50;
    logic                       KEY0;
    logic                       req_valid;
    logic                       req_ready;
    bus_req_t                   req;
    logic                       resp_valid;
    logic                       resp_ready;
    bus_resp_t                  resp;
    logic [`PLIC_SOURCES-1:0]   irq_src;
    logic [`PLIC_CONTEXTS-1:0]  ext_irq;

    logic [7:0]  model [4*`RAM_WORDS];
    logic [31:0] lfsr_q;
    int          errors;
    int          tests_ok;
    int          tests_bad;

    soc_bus_top dut (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .irq_src    (irq_src),
        .ext_irq    (ext_irq)
    );

    always #(clk_period / 2) CLOCK_50 = ~CLOCK_50;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // expected load from the byte model, little-endian
    function automatic logic [63:0] model_load(input logic [31:0] a, input ls_size_e sz);
        int          n;
        logic [63:0] v;
        n = 1 << sz[1:0];
        v = '0;
        for (int i = n - 1; i >= 0; i--) begin
            v = {v[55:0], model[(a - ram) + i]};
        end
        // sign extension only for lb, lh, lw
        if (!sz[2] && n < 8 && v[8*n-1]) begin
            v = v | (64'hffff_ffff_ffff_ffff << (8 * n));
        end
        return v;
    endfunction

    task automatic model_store(input logic [31:0] a, input ls_size_e sz, input logic [63:0] d);
        for (int i = 0; i < (1 << sz[1:0]); i++) begin
            model[(a - ram) + i] = d[8*i +: 8];
        end
    endtask

    task automatic check_resp(input bus_resp_t got, input bus_resp_t exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got data %h err %b, expected data %h err %b",
                     $time, msg, got.rdata, got.err, exp.rdata, exp.err);
            errors++;
        end
    endtask

    task automatic check_irq(input logic [`PLIC_CONTEXTS-1:0] got,
                             input logic [`PLIC_CONTEXTS-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s ext_irq %b, expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    // all tasks start and end one unit after a rising edge
    task automatic issue_req(input bus_req_t r);
        req_valid = 1'b1;
        req = r;
        while (!req_ready) begin
            @(posedge CLOCK_50);
            #1;
        end
        // accepted on this edge
        @(posedge CLOCK_50);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic take_resp(output bus_resp_t rs);
        resp_ready = 1'b1;
        while (!resp_valid) begin
            @(posedge CLOCK_50);
            #1;
        end
        rs = resp;
        @(posedge CLOCK_50);
        #1;
        resp_ready = 1'b0;
    endtask

    task automatic send(input bus_req_t r, output bus_resp_t rs);
        issue_req(r);
        take_resp(rs);
    endtask

    function automatic bus_req_t make_req(input logic [31:0] a, input logic w,
                                          input ls_size_e sz, input logic [63:0] d);
        bus_req_t r;
        r.addr = a;
        r.write = w;
        r.size = sz;
        r.wdata = d;
        return r;
    endfunction

    task automatic bus_write(input logic [31:0] a, input ls_size_e sz, input logic [63:0] d,
                             output bus_resp_t rs);
        send(make_req(a, 1'b1, sz, d), rs);
    endtask

    task automatic bus_read(input logic [31:0] a, input ls_size_e sz, output bus_resp_t rs);
        send(make_req(a, 1'b0, sz, 64'd0), rs);
    endtask

    // ram store that also updates the model and expects no error
    task automatic ram_store(input logic [31:0] a, input ls_size_e sz, input logic [63:0] d);
        bus_resp_t rs;
        bus_write(a, sz, d, rs);
        model_store(a, sz, d);
        check_resp(rs, '{rdata: 64'd0, err: 1'b0}, "ram store");
    endtask

    task automatic ram_check(input logic [31:0] a, input ls_size_e sz, input string msg);
        bus_resp_t rs;
        bus_read(a, sz, rs);
        check_resp(rs, '{rdata: model_load(a, sz), err: 1'b0}, msg);
    endtask

    task automatic plic_write(input logic [31:0] ofs, input logic [31:0] d);
        bus_resp_t rs;
        bus_write(pl + ofs, ls_lw, {32'd0, d}, rs);
        check_resp(rs, '{rdata: 64'd0, err: 1'b0}, "plic write");
    endtask

    task automatic plic_expect(input logic [31:0] ofs, input logic [31:0] exp,
                               input string msg);
        bus_resp_t rs;
        bus_read(pl + ofs, ls_lw, rs);
        check_resp(rs, '{rdata: {32'd0, exp}, err: 1'b0}, msg);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s ok", name);
            tests_ok++;
        end else begin
            $display("test %s failed with %0d errors", name, errors - err_before);
            tests_bad++;
        end
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(resp_valid, 1'b0, "resp_valid after reset");
        check_irq(ext_irq, '0, "after reset");
        plic_expect(`PLIC_CLAIM_OFS, 0, "claim ctx0 after reset");
        plic_expect(`PLIC_CLAIM_OFS + `PLIC_CTX_STRIDE, 0, "claim ctx1 after reset");
        report_test("reset", e);
    endtask

    task automatic test_sized();
        int          e;
        logic [31:0] a;
        e = errors;
        for (int w = 0; w < 4; w++) begin
            a = ram + 32'h40 + 8 * w;
            ram_store(a, ls_lw, rand_bits(32));
            // halves and bytes over every legal lane
            ram_store(a + 2 * (w % 2), ls_lh, rand_bits(16));
            ram_store(a + (w % 4), ls_lb, rand_bits(8));
            for (int k = 0; k < 4; k++) begin
                ram_check(a + k, ls_lb, "lb");
                ram_check(a + k, ls_lbu, "lbu");
            end
            for (int k = 0; k < 4; k += 2) begin
                ram_check(a + k, ls_lh, "lh");
                ram_check(a + k, ls_lhu, "lhu");
            end
            ram_check(a, ls_lw, "lw");
            ram_check(a, ls_lwu, "lwu");
        end
        report_test("sized", e);
    endtask

    task automatic test_double();
        int e;
        e = errors;
        for (int i = 0; i < 2; i++) begin
            ram_store(ram + 32'h100 + 8 * i, ls_ld, rand_bits(64));
            ram_check(ram + 32'h100 + 8 * i, ls_ld, "ld");
            // low half sits at the lower address
            ram_check(ram + 32'h100 + 8 * i, ls_lw, "lw low half");
            ram_check(ram + 32'h104 + 8 * i, ls_lw, "lw high half");
        end
        report_test("double", e);
    endtask

    task automatic test_plic();
        int e;
        e = errors;
        // priorities, source 6 only equals the ctx0 threshold
        plic_write(4 * 1, 1);
        plic_write(4 * 2, 3);
        plic_write(4 * 3, 2);
        plic_write(4 * 5, 4);
        plic_write(4 * 6, 1);
        plic_write(`PLIC_THRESH_OFS, 1);
        plic_write(`PLIC_THRESH_OFS + `PLIC_CTX_STRIDE, 3);
        plic_write(`PLIC_ENABLE_OFS, 32'h6e);
        // ctx1 only sees source 1, whose priority is too low
        plic_write(`PLIC_ENABLE_OFS + `PLIC_ENABLE_STRIDE, 32'h02);
        plic_expect(4 * 2, 3, "priority readback");
        check_irq(ext_irq, 2'b00, "before edges");
        irq_src = 8'h6e;
        @(posedge CLOCK_50);
        #1;
        irq_src = 8'h00;
        // edge capture goes through two flops
        repeat (3) @(posedge CLOCK_50);
        #1;
        check_irq(ext_irq, 2'b01, "after edges");
        plic_expect(`PLIC_PENDING_OFS, 32'h6e, "pending after edges");
        plic_expect(`PLIC_CLAIM_OFS + `PLIC_CTX_STRIDE, 0, "claim ctx1");
        plic_expect(`PLIC_CLAIM_OFS, 5, "claim 5");
        plic_expect(`PLIC_CLAIM_OFS, 3, "claim 3");
        check_irq(ext_irq, 2'b01, "one source left");
        plic_expect(`PLIC_CLAIM_OFS, 2, "claim 2");
        plic_expect(`PLIC_CLAIM_OFS, 0, "claim empty");
        check_irq(ext_irq, 2'b00, "after claims");
        // sources 1 and 6 never eligible
        plic_expect(`PLIC_PENDING_OFS, 32'h42, "pending after claims");
        report_test("plic", e);
    endtask

    task automatic test_errors();
        int        e;
        bus_resp_t rs;
        e = errors;
        ram_store(ram, ls_ld, rand_bits(64));
        // word right above the misaligned double
        ram_store(ram + 8, ls_lw, rand_bits(32));
        bus_read(32'h4000_0000, ls_lw, rs);
        check_resp(rs, '{rdata: 64'd0, err: 1'b1}, "unmapped read");
        bus_write(ram + 1, ls_lh, 64'hffff, rs);
        check_resp(rs, '{rdata: 64'd0, err: 1'b1}, "misaligned half");
        bus_write(ram + 2, ls_lw, 64'hffff_ffff, rs);
        check_resp(rs, '{rdata: 64'd0, err: 1'b1}, "misaligned word");
        bus_write(ram + 4, ls_ld, 64'hffff_ffff_ffff_ffff, rs);
        check_resp(rs, '{rdata: 64'd0, err: 1'b1}, "misaligned double");
        // nothing above may have landed
        ram_check(ram, ls_ld, "ram after errors");
        ram_check(ram + 8, ls_lw, "next word after errors");
        report_test("errors", e);
    endtask

    task automatic test_backpressure();
        int        e;
        bus_resp_t held;
        bus_resp_t rs;
        bus_req_t  second;
        e = errors;
        issue_req(make_req(ram + 32'h100, 1'b0, ls_ld, 64'd0));
        while (!resp_valid) begin
            @(posedge CLOCK_50);
            #1;
        end
        held = '{rdata: model_load(ram + 32'h100, ls_ld), err: 1'b0};
        check_resp(resp, held, "held ld");
        // next request waits behind the response
        second = make_req(ram + 32'h44, 1'b0, ls_lw, 64'd0);
        req_valid = 1'b1;
        req = second;
        repeat (5) begin
            @(posedge CLOCK_50);
            #1;
            check_resp(resp, held, "response under back-pressure");
            check_flag(resp_valid, 1'b1, "resp_valid under back-pressure");
            check_flag(req_ready, 1'b0, "req_ready under back-pressure");
        end
        take_resp(rs);
        check_resp(rs, held, "response after release");
        send(second, rs);
        check_resp(rs, '{rdata: model_load(ram + 32'h44, ls_lw), err: 1'b0}, "second request");
        report_test("backpressure", e);
    endtask

    // watchdog
    initial begin
        #((num_trans * 20 + 4) * clk_period);
        $display("the run timed out before all tests finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b0;
        irq_src = '0;
        lfsr_q = 32'd70;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        for (int i = 0; i < 4 * `RAM_WORDS; i++) begin
            model[i] = 8'hxx;
        end
        repeat (2) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        test_reset();
        test_sized();
        test_double();
        test_plic();
        test_errors();
        test_backpressure();
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- soc_bus_top.f
+incdir+.
soc_bus_pkg.sv
bus_decoder.sv
ram_port.sv
plic.sv
soc_bus_top.sv
soc_bus_properties.sv
tb_soc_bus_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f soc_bus_top.f --top-module tb_soc_bus_top -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1
